//--- common/agu_pkg.sv
`default_nettype none

package agu_pkg;

  // address geometry
  localparam int VADDR_W    = 44;
  localparam int PADDR_W    = 44;
  localparam int PAGE_BITS  = 13;
  localparam int LINE_BITS  = 7;
  localparam int BANK_COUNT = 32;
  localparam int ASID_W     = 21;

  localparam int PFN_W      = PADDR_W - PAGE_BITS;
  localparam int VPN_W      = VADDR_W - PAGE_BITS;
  localparam int WALK_VPN_W = ASID_W + VPN_W;
  localparam int LINE_IDX_W = PAGE_BITS - LINE_BITS;

  localparam int SZ_W       = 5;
  localparam int BANK_IDX_W = 5;
  localparam int REG_W      = 9;
  localparam int LSQ_W      = 9;

  // operation size codes
  localparam logic [SZ_W-1:0] SZ_128U0 = 5'd0;
  localparam logic [SZ_W-1:0] SZ_128U1 = 5'd1;
  localparam logic [SZ_W-1:0] SZ_128U2 = 5'd2;
  localparam logic [SZ_W-1:0] SZ_LDBL  = 5'd3;
  localparam logic [SZ_W-1:0] SZ_SGL0  = 5'd4;
  localparam logic [SZ_W-1:0] SZ_SGL1  = 5'd5;
  localparam logic [SZ_W-1:0] SZ_SGL2  = 5'd6;
  localparam logic [SZ_W-1:0] SZ_DBL0  = 5'd8;
  localparam logic [SZ_W-1:0] SZ_DBL1  = 5'd9;
  localparam logic [SZ_W-1:0] SZ_DBL2  = 5'd10;
  localparam logic [SZ_W-1:0] SZ_128A0 = 5'd12;
  localparam logic [SZ_W-1:0] SZ_128A1 = 5'd13;
  localparam logic [SZ_W-1:0] SZ_128A2 = 5'd14;
  localparam logic [SZ_W-1:0] SZ_FILL  = 5'd15;
  localparam logic [SZ_W-1:0] SZ_B1    = 5'd16;
  localparam logic [SZ_W-1:0] SZ_B2    = 5'd17;
  localparam logic [SZ_W-1:0] SZ_B4    = 5'd18;
  localparam logic [SZ_W-1:0] SZ_B8    = 5'd19;

  // control registers
  localparam logic [15:0] CSR_PAGE   = 16'h0020;
  localparam logic [15:0] CSR_VMPAGE = 16'h0021;
  localparam logic [15:0] CSR_MFLAGS = 16'h0022;
  localparam int          MF_KM_BIT  = 0;

  localparam logic [1:0] CPL_KERNEL = 2'd0;
  localparam logic [1:0] CPL_USER   = 2'd3;

  // walk request sources
  localparam logic [1:0] WSRC_MISS = 2'd0;
  localparam logic [1:0] WSRC_EXT  = 2'd1;
  localparam logic [1:0] WSRC_CODE = 2'd2;

  typedef enum logic [2:0] {
    OPS_1, OPS_2, OPS_SGL, OPS_DBL, OPS_LDBL, OPS_128, OPS_FILL
  } opsize_e;

  typedef struct packed {
    logic spare;
    logic sec;
    logic km;
    logic vm;
  } mop_attr_t;

  typedef struct packed {
    logic                  en;
    logic                  st;
    logic [SZ_W-1:0]       sz;
    logic [BANK_IDX_W-1:0] bank0;
    logic [VADDR_W-1:0]    vaddr;
    logic [REG_W-1:0]      reg_no;
    logic [LSQ_W-1:0]      lsq;
    mop_attr_t             attr;
  } mop_t;

  typedef struct packed {
    logic [PFN_W-1:0] phys;
    logic             sys;
    logic             na;
    logic             glo;
  } tlb_entry_t;

  typedef struct packed {
    logic [WALK_VPN_W-1:0] vpn;
    mop_attr_t             attr;
    logic [1:0]            src;
  } walk_req_t;

  typedef struct packed {
    logic                         en;
    logic                         st;
    logic [SZ_W-1:0]              sz;
    logic [REG_W-1:0]             reg_no;
    logic [LSQ_W-1:0]             lsq;
    logic [BANK_COUNT-1:0]        banks;
    logic [BANK_IDX_W-1:0]        bank0;
    logic                         odd;
    logic [1:0]                   addr_low;
    logic [PADDR_W-1:LINE_BITS+1] addr_even;
    logic [PADDR_W-1:LINE_BITS+1] addr_odd;
  } mop_out_t;

endpackage

`default_nettype wire

//--- agu/mop_stage.sv
`default_nettype none

module mop_stage (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           except,
  input  logic                           rs_stall,
  input  logic                           stall,
  input  agu_pkg::mop_t                  mop_in,
  input  logic [agu_pkg::ASID_W-1:0]     proc_base,
  output agu_pkg::mop_t                  mop_q,
  output logic [agu_pkg::WALK_VPN_W-1:0] tlb_addr
);
  import agu_pkg::*;

  mop_t op_q;
  logic en_q;
  logic hold;

  assign hold = stall || rs_stall;

  // valid bit, killed by an exception even while held
  always_ff @(posedge clk) begin
    if (rst) begin
      en_q <= 1'b0;
    end else if (except) begin
      en_q <= 1'b0;
    end else if (!hold) begin
      en_q <= mop_in.en;
    end
  end

  always_ff @(posedge clk) begin
    if (!hold && mop_in.en) begin
      op_q <= mop_in;
    end
  end

  always_comb begin
    mop_q    = op_q;
    mop_q.en = en_q;
  end

  // lookup key is address-space base plus virtual page number
  assign tlb_addr = {proc_base, op_q.vaddr[VADDR_W-1:PAGE_BITS]};

endmodule

`default_nettype wire

//--- agu/bank_mask.sv
`default_nettype none

module bank_mask (
  input  logic [agu_pkg::SZ_W-1:0]       sz,
  input  logic [agu_pkg::BANK_IDX_W-1:0] bank0,
  input  logic [1:0]                     addr_low,
  output logic [agu_pkg::BANK_COUNT-1:0] banks
);
  import agu_pkg::*;

  opsize_e    ops;
  logic       a;
  logic       b;
  logic [2:0] n;

  always_comb begin
    case (sz)
      SZ_B1:                         ops = OPS_1;
      SZ_B2:                         ops = OPS_2;
      SZ_B4, SZ_SGL0, SZ_SGL1, SZ_SGL2: ops = OPS_SGL;
      SZ_B8, SZ_DBL0, SZ_DBL1, SZ_DBL2: ops = OPS_DBL;
      SZ_LDBL:                       ops = OPS_LDBL;
      SZ_128U0, SZ_128U1, SZ_128U2,
      SZ_128A0, SZ_128A1, SZ_128A2:  ops = OPS_128;
      SZ_FILL:                       ops = OPS_FILL;
      default:                       ops = OPS_DBL;
    endcase
  end

  // unaligned low bits spill into one more bank
  assign a = addr_low != 2'd0;
  assign b = addr_low == 2'd3;

  always_comb begin
    case (ops)
      OPS_1:    n = 3'd1;
      OPS_2:    n = 3'd1 + {2'b0, b};
      OPS_SGL:  n = 3'd1 + {2'b0, a};
      OPS_DBL:  n = 3'd2 + {2'b0, a};
      OPS_LDBL: n = 3'd4 + {2'b0, b};
      OPS_128:  n = 3'd4 + {2'b0, a};
      default:  n = 3'd5;
    endcase
  end

  for (genvar i = 0; i < BANK_COUNT; i++) begin : g_bank
    logic [BANK_IDX_W-1:0] ofs;

    // distance from bank0, wraps around the bank ring
    assign ofs      = BANK_IDX_W'(i) - bank0;
    assign banks[i] = ofs < {2'b0, n};
  end

endmodule

`default_nettype wire

//--- agu/line_addr.sv
`default_nettype none

module line_addr (
  input  logic                                           clk,
  input  logic                                           rst,
  input  logic [agu_pkg::VADDR_W-1:0]                    vaddr,
  input  logic                                           tlb_hit,
  input  agu_pkg::tlb_entry_t                            tlb_entry,
  input  agu_pkg::tlb_entry_t                            tlb_entry_next,
  input  logic [1:0]                                     cpl,
  input  logic                                           out_en,
  output logic [agu_pkg::PADDR_W-1:agu_pkg::LINE_BITS+1] addr_even,
  output logic [agu_pkg::PADDR_W-1:agu_pkg::LINE_BITS+1] addr_odd,
  output logic                                           odd,
  output logic                                           page_fault,
  output logic [1:0]                                     fault_code
);
  import agu_pkg::*;

  logic [LINE_IDX_W-1:0] idx;
  logic [LINE_IDX_W-1:0] idx_next;
  logic                  page_carry;
  logic [PFN_W-1:0]      pfn_even;
  logic [1:0]            fault_cur;
  logic [1:0]            fault_nxt;
  logic [1:0]            fault_t;
  logic [1:0]            fault_q;
  logic                  en_q;

  assign idx                    = vaddr[PAGE_BITS-1:LINE_BITS];
  assign {page_carry, idx_next} = {1'b0, idx} + 1'b1;
  assign odd                    = vaddr[LINE_BITS];

  // carry only happens from the last line, which is odd, so only the even line moves
  assign pfn_even  = page_carry ? tlb_entry_next.phys : tlb_entry.phys;
  assign addr_even = {pfn_even, odd ? idx_next[LINE_IDX_W-1:1] : idx[LINE_IDX_W-1:1]};
  assign addr_odd  = {tlb_entry.phys, idx[LINE_IDX_W-1:1]};

  // bit 1 sys page at user level, bit 0 not accessible
  assign fault_cur = {cpl == CPL_USER && tlb_entry.sys, !tlb_entry.na};
  assign fault_nxt = {cpl == CPL_USER && tlb_entry_next.sys, !tlb_entry_next.na};
  assign fault_t   = (fault_cur | (page_carry ? fault_nxt : 2'b00)) & {2{tlb_hit}};

  always_ff @(posedge clk) begin
    if (rst) begin
      fault_q <= 2'b00;
      en_q    <= 1'b0;
    end else begin
      fault_q <= fault_t;
      en_q    <= out_en;
    end
  end

  assign page_fault = en_q && (fault_q != 2'b00);
  assign fault_code = fault_q;

endmodule

`default_nettype wire

//--- agu/walk_arbiter.sv
`default_nettype none

module walk_arbiter (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           ext_req,
  input  logic [agu_pkg::WALK_VPN_W-1:0] ext_vpn,
  input  agu_pkg::mop_attr_t             ext_attr,
  input  logic                           code_req,
  input  logic [agu_pkg::WALK_VPN_W-1:0] code_vpn,
  input  agu_pkg::mop_attr_t             code_attr,
  input  logic                           miss,
  input  logic [agu_pkg::WALK_VPN_W-1:0] miss_vpn,
  input  agu_pkg::mop_attr_t             miss_attr,
  input  logic                           walk_done,
  output logic                           walk_req_en,
  output agu_pkg::walk_req_t             walk_req,
  output logic                           walk_busy,
  output logic                           ext_ack
);
  import agu_pkg::*;

  walk_req_t ext_new;
  walk_req_t code_new;
  walk_req_t miss_new;
  walk_req_t ext_slot;
  walk_req_t code_slot;
  walk_req_t pick;
  logic      ext_v;
  logic      code_v;
  logic      free;
  logic      sel_ext_slot;
  logic      sel_ext_new;
  logic      sel_code_slot;
  logic      sel_code_new;
  logic      sel_miss;
  logic      issue;

  assign ext_new  = '{vpn: ext_vpn, attr: ext_attr, src: WSRC_EXT};
  assign code_new = '{vpn: code_vpn, attr: code_attr, src: WSRC_CODE};
  assign miss_new = '{vpn: miss_vpn, attr: miss_attr, src: WSRC_MISS};

  // a finishing walk frees the walker for the next request
  assign free = !walk_busy || walk_done;

  // saved requests go before new ones of the same source
  assign sel_ext_slot  = free && ext_v;
  assign sel_ext_new   = free && !ext_v && ext_req;
  assign sel_code_slot = free && !ext_v && !ext_req && code_v;
  assign sel_code_new  = free && !ext_v && !ext_req && !code_v && code_req;
  // held op re-raises its miss only once the walker is idle
  assign sel_miss      = !walk_busy && !ext_v && !ext_req && !code_v && !code_req && miss;

  assign issue = sel_ext_slot || sel_ext_new || sel_code_slot || sel_code_new || sel_miss;

  always_comb begin
    if (sel_ext_slot) begin
      pick = ext_slot;
    end else if (sel_ext_new) begin
      pick = ext_new;
    end else if (sel_code_slot) begin
      pick = code_slot;
    end else if (sel_code_new) begin
      pick = code_new;
    end else begin
      pick = miss_new;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      walk_busy   <= 1'b0;
      walk_req_en <= 1'b0;
      ext_v       <= 1'b0;
      code_v      <= 1'b0;
    end else begin
      walk_req_en <= issue;
      if (issue) begin
        walk_busy <= 1'b1;
      end else if (walk_done) begin
        walk_busy <= 1'b0;
      end
      if (ext_req && !sel_ext_new) begin
        ext_v <= 1'b1;
      end else if (sel_ext_slot) begin
        ext_v <= 1'b0;
      end
      if (code_req && !sel_code_new) begin
        code_v <= 1'b1;
      end else if (sel_code_slot) begin
        code_v <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      walk_req <= pick;
    end
    if (ext_req && !sel_ext_new) begin
      ext_slot <= ext_new;
    end
    if (code_req && !sel_code_new) begin
      code_slot <= code_new;
    end
  end

  assign ext_ack = walk_busy && walk_done && (walk_req.src == WSRC_EXT);

endmodule

`default_nettype wire

//--- rtl/page_csr.sv
`default_nettype none

module page_csr (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       csr_en,
  input  logic [15:0]                csr_no,
  input  logic [63:0]                csr_data,
  input  agu_pkg::mop_attr_t         attr,
  output logic [agu_pkg::ASID_W-1:0] proc_base,
  output logic [1:0]                 cpl
);
  import agu_pkg::*;

  logic [ASID_W-1:0] pproc;
  logic [ASID_W-1:0] vproc;
  logic              km_flag;

  // base lives in the top bits of the written word
  always_ff @(posedge clk) begin
    if (rst) begin
      pproc   <= '0;
      vproc   <= '0;
      km_flag <= 1'b0;
    end else if (csr_en) begin
      case (csr_no)
        CSR_PAGE:   pproc   <= csr_data[63 -: ASID_W];
        CSR_VMPAGE: vproc   <= csr_data[63 -: ASID_W];
        CSR_MFLAGS: km_flag <= csr_data[MF_KM_BIT];
        default:    ;
      endcase
    end
  end

  assign proc_base = attr.vm ? vproc : pproc;
  // kernel flag forces privileged access for every op
  assign cpl       = (attr.km || km_flag) ? CPL_KERNEL : CPL_USER;

endmodule

`default_nettype wire

//--- rtl/agu_top.sv
`default_nettype none

module agu_top (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            except,
  input  logic                            rs_stall,
  input  agu_pkg::mop_t                   mop_in,
  output logic                            stall,
  output logic [agu_pkg::WALK_VPN_W-1:0]  tlb_addr,
  input  logic                            tlb_hit,
  input  agu_pkg::tlb_entry_t             tlb_entry,
  input  agu_pkg::tlb_entry_t             tlb_entry_next,
  input  logic                            ext_req,
  input  logic [agu_pkg::WALK_VPN_W-1:0]  ext_vpn,
  input  agu_pkg::mop_attr_t              ext_attr,
  input  logic                            code_req,
  input  logic [agu_pkg::WALK_VPN_W-1:0]  code_vpn,
  input  agu_pkg::mop_attr_t              code_attr,
  input  logic                            walk_done,
  output logic                            walk_req_en,
  output agu_pkg::walk_req_t              walk_req,
  output logic                            ext_ack,
  input  logic                            csr_en,
  input  logic [15:0]                     csr_no,
  input  logic [63:0]                     csr_data,
  output agu_pkg::mop_out_t               mop_out,
  output logic                            page_fault,
  output logic [1:0]                      fault_code
);
  import agu_pkg::*;

  mop_t                         mop_q;
  logic [ASID_W-1:0]            proc_base;
  logic [1:0]                   cpl;
  logic                         walk_busy;
  logic                         miss;
  logic                         stall_core;
  logic                         out_en;
  logic [BANK_COUNT-1:0]        banks;
  logic [PADDR_W-1:LINE_BITS+1] addr_even;
  logic [PADDR_W-1:LINE_BITS+1] addr_odd;
  logic                         odd;

  assign miss       = mop_q.en && !tlb_hit;
  // any pending walk request holds the operation in place
  assign stall_core = miss || walk_busy || ext_req || code_req;
  assign stall      = stall_core || rs_stall;
  assign out_en     = mop_q.en && !stall && !except;

  mop_stage u_mop_stage (
    .clk       (clk),
    .rst       (rst),
    .except    (except),
    .rs_stall  (rs_stall),
    .stall     (stall_core),
    .mop_in    (mop_in),
    .proc_base (proc_base),
    .mop_q     (mop_q),
    .tlb_addr  (tlb_addr)
  );

  bank_mask u_bank_mask (
    .sz       (mop_q.sz),
    .bank0    (mop_q.bank0),
    .addr_low (mop_q.vaddr[1:0]),
    .banks    (banks)
  );

  line_addr u_line_addr (
    .clk            (clk),
    .rst            (rst),
    .vaddr          (mop_q.vaddr),
    .tlb_hit        (tlb_hit),
    .tlb_entry      (tlb_entry),
    .tlb_entry_next (tlb_entry_next),
    .cpl            (cpl),
    .out_en         (out_en),
    .addr_even      (addr_even),
    .addr_odd       (addr_odd),
    .odd            (odd),
    .page_fault     (page_fault),
    .fault_code     (fault_code)
  );

  walk_arbiter u_walk_arbiter (
    .clk         (clk),
    .rst         (rst),
    .ext_req     (ext_req),
    .ext_vpn     (ext_vpn),
    .ext_attr    (ext_attr),
    .code_req    (code_req),
    .code_vpn    (code_vpn),
    .code_attr   (code_attr),
    .miss        (miss),
    .miss_vpn    (tlb_addr),
    .miss_attr   (mop_q.attr),
    .walk_done   (walk_done),
    .walk_req_en (walk_req_en),
    .walk_req    (walk_req),
    .walk_busy   (walk_busy),
    .ext_ack     (ext_ack)
  );

  page_csr u_page_csr (
    .clk       (clk),
    .rst       (rst),
    .csr_en    (csr_en),
    .csr_no    (csr_no),
    .csr_data  (csr_data),
    .attr      (mop_q.attr),
    .proc_base (proc_base),
    .cpl       (cpl)
  );

  always_comb begin
    mop_out.en        = out_en;
    mop_out.st        = mop_q.st;
    mop_out.sz        = mop_q.sz;
    mop_out.reg_no    = mop_q.reg_no;
    mop_out.lsq       = mop_q.lsq;
    mop_out.banks     = out_en ? banks : '0;
    mop_out.bank0     = mop_q.bank0;
    mop_out.odd       = odd;
    mop_out.addr_low  = mop_q.vaddr[1:0];
    mop_out.addr_even = addr_even;
    mop_out.addr_odd  = addr_odd;
  end

endmodule

`default_nettype wire

//--- bench/tb_agu.sv
`default_nettype none

module tb_agu;
  timeunit 1ns;
  timeprecision 1ps;
  import agu_pkg::*;

  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 200;
  localparam int WALK_DELAY      = 4;
  localparam logic [31:0] SEED   = 32'hed0b_f875;

  logic                  clk;
  logic                  rst;
  logic                  except;
  logic                  rs_stall;
  mop_t                  mop_in;
  logic                  stall;
  logic [WALK_VPN_W-1:0] tlb_addr;
  logic                  tlb_hit;
  tlb_entry_t            tlb_entry;
  tlb_entry_t            tlb_entry_next;
  logic                  ext_req;
  logic [WALK_VPN_W-1:0] ext_vpn;
  mop_attr_t             ext_attr;
  logic                  code_req;
  logic [WALK_VPN_W-1:0] code_vpn;
  mop_attr_t             code_attr;
  logic                  walk_done;
  logic                  walk_req_en;
  walk_req_t             walk_req;
  logic                  ext_ack;
  logic                  csr_en;
  logic [15:0]           csr_no;
  logic [63:0]           csr_data;
  mop_out_t              mop_out;
  logic                  page_fault;
  logic [1:0]            fault_code;

  // TLB contents keyed by {proc base, virtual page}
  tlb_entry_t tlb_map [logic [WALK_VPN_W-1:0]];
  int         tlb_version = 0;
  walk_req_t  walks[$];
  int         ack_count = 0;
  int         errors = 0;
  string      test_name = "none";
  logic [31:0] rand_state = SEED;
  logic [ASID_W-1:0] pbase = '0;
  logic [ASID_W-1:0] vbase = '0;
  logic [SZ_W-1:0] size_codes [18] = '{SZ_128U0, SZ_128U1, SZ_128U2, SZ_LDBL, SZ_SGL0,
    SZ_SGL1, SZ_SGL2, SZ_DBL0, SZ_DBL1, SZ_DBL2, SZ_128A0, SZ_128A1, SZ_128A2, SZ_FILL,
    SZ_B1, SZ_B2, SZ_B4, SZ_B8};

  agu_top u_agu_top (
    .clk (clk), .rst (rst), .except (except), .rs_stall (rs_stall), .mop_in (mop_in),
    .stall (stall), .tlb_addr (tlb_addr), .tlb_hit (tlb_hit), .tlb_entry (tlb_entry),
    .tlb_entry_next (tlb_entry_next), .ext_req (ext_req), .ext_vpn (ext_vpn),
    .ext_attr (ext_attr), .code_req (code_req), .code_vpn (code_vpn),
    .code_attr (code_attr), .walk_done (walk_done), .walk_req_en (walk_req_en),
    .walk_req (walk_req), .ext_ack (ext_ack), .csr_en (csr_en), .csr_no (csr_no),
    .csr_data (csr_data), .mop_out (mop_out), .page_fault (page_fault),
    .fault_code (fault_code)
  );

  // version argument retriggers the lookup after an install
  function automatic tlb_entry_t tlb_lookup(input logic [WALK_VPN_W-1:0] key, input int ver);
    if (tlb_map.exists(key)) begin
      return tlb_map[key];
    end
    return '0;
  endfunction

  function automatic logic tlb_present(input logic [WALK_VPN_W-1:0] key, input int ver);
    return tlb_map.exists(key);
  endfunction

  assign tlb_hit        = tlb_present(tlb_addr, tlb_version);
  assign tlb_entry      = tlb_lookup(tlb_addr, tlb_version);
  assign tlb_entry_next = tlb_lookup(tlb_addr + 1'b1, tlb_version);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  function automatic logic [PFN_W-1:0] frame_of(input logic [WALK_VPN_W-1:0] key);
    return key[PFN_W-1:0] ^ 31'h2a5a_5a5a;
  endfunction

  function automatic logic [WALK_VPN_W-1:0] tlb_key(input logic [VADDR_W-1:0] va,
                                                    input logic vm);
    return {vm ? vbase : pbase, va[VADDR_W-1:PAGE_BITS]};
  endfunction

  function automatic mop_attr_t attr_of(input logic km, input logic vm);
    return '{spare: 1'b0, sec: 1'b0, km: km, vm: vm};
  endfunction

  function automatic mop_t make_op(input logic [VADDR_W-1:0] va, input logic [SZ_W-1:0] sz,
                                   input logic [4:0] bank0, input mop_attr_t attr);
    mop_t op;
    op.en     = 1'b1;
    op.st     = next_rand() & 1;
    op.sz     = sz;
    op.bank0  = bank0;
    op.vaddr  = va;
    op.reg_no = next_rand() % 512;
    op.lsq    = next_rand() % 512;
    op.attr   = attr;
    return op;
  endfunction

  // n consecutive banks from bank0 with n set by size class and low address bits
  function automatic logic [31:0] expected_banks(input logic [4:0] sz, input logic [4:0] bank0,
                                                 input logic [1:0] low);
    int          n;
    int          a;
    int          b;
    logic [31:0] m;
    a = (low != 2'd0) ? 1 : 0;
    b = (low == 2'd3) ? 1 : 0;
    if (sz == SZ_B1) n = 1;
    else if (sz == SZ_B2) n = 1 + b;
    else if (sz == SZ_B4 || (sz >= 5'd4 && sz <= 5'd6)) n = 1 + a;
    else if (sz == SZ_B8 || (sz >= 5'd8 && sz <= 5'd10)) n = 2 + a;
    else if (sz == SZ_LDBL) n = 4 + b;
    else if (sz == SZ_FILL) n = 5;
    else n = 4 + a;
    m = '0;
    for (int k = 0; k < n; k++) begin
      m[(bank0 + k) % 32] = 1'b1;
    end
    return m;
  endfunction

  // even line is line+1 when the access starts on an odd line
  function automatic logic [35:0] even_line(input logic [VADDR_W-1:0] va,
                                            input logic [PFN_W-1:0] pfn,
                                            input logic [PFN_W-1:0] pfn_next);
    logic [6:0] line;
    line = {1'b0, va[12:7]};
    if (!line[0]) begin
      return {pfn, line[5:1]};
    end
    line = line + 7'd1;
    return {line[6] ? pfn_next : pfn, line[5:1]};
  endfunction

  task automatic fail_run();
    errors++;
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected) else begin
      $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, expected, actual);
      fail_run();
    end
  endtask

  task automatic install_page(input logic [WALK_VPN_W-1:0] key, input logic sys, input logic na);
    tlb_map[key] = '{phys: frame_of(key), sys: sys, na: na, glo: 1'b0};
    tlb_version++;
  endtask

  // entered and left on a falling edge
  task automatic issue_op(input mop_t op);
    mop_in = op;
    @(negedge clk);
    mop_in.en = 1'b0;
  endtask

  task automatic write_csr(input logic [15:0] no, input logic [ASID_W-1:0] base);
    csr_en   = 1'b1;
    csr_no   = no;
    csr_data = 64'(base) << (64 - ASID_W);
    @(negedge clk);
    csr_en = 1'b0;
  endtask

  task automatic wait_out_en(input int limit);
    int n;
    n = 0;
    while (mop_out.en !== 1'b1 && n < limit) begin
      @(negedge clk);
      n++;
    end
    assert (mop_out.en === 1'b1) else begin
      $display("%s: operation did not complete within %0d cycles", test_name, limit);
      fail_run();
    end
  endtask

  task automatic wait_walks(input int count, input int limit);
    int n;
    n = 0;
    while (walks.size() < count && n < limit) begin
      @(negedge clk);
      n++;
    end
    assert (walks.size() >= count) else begin
      $display("%s: only %0d of %0d walks issued", test_name, walks.size(), count);
      fail_run();
    end
  endtask

  // walker installs the page and checks ext_ack on each completion
  initial begin : walker_model
    walk_req_t req;
    walk_done = 1'b0;
    forever begin
      @(negedge clk);
      walk_done = 1'b0;
      if (walk_req_en === 1'b1) begin
        req = walk_req;
        walks.push_back(req);
        repeat (WALK_DELAY) @(negedge clk);
        install_page(req.vpn, 1'b0, 1'b1);
        walk_done = 1'b1;
        #1;
        check_value("ext_ack", req.src == WSRC_EXT, ext_ack);
        if (ext_ack === 1'b1) ack_count++;
      end
    end
  end

  task automatic reset_then_hit();
    mop_t op;
    test_name = "reset_and_hit";
    check_value("mop_out.en", 0, mop_out.en);
    check_value("walk_req_en", 0, walk_req_en);
    check_value("page_fault", 0, page_fault);
    check_value("stall", 0, stall);
    check_value("ext_ack", 0, ext_ack);
    op = make_op({31'h0100, 13'h0088}, SZ_B4, 5'd3, attr_of(1'b1, 1'b0));
    install_page(tlb_key(op.vaddr, 1'b0), 1'b0, 1'b1);
    issue_op(op);
    check_value("mop_out.en", 1, mop_out.en);
    check_value("reg_no", op.reg_no, mop_out.reg_no);
    check_value("lsq", op.lsq, mop_out.lsq);
    check_value("st", op.st, mop_out.st);
    @(negedge clk);
    check_value("mop_out.en idle", 0, mop_out.en);
  endtask

  task automatic random_bank_masks();
    mop_t             op;
    logic [SZ_W-1:0]  sz;
    logic [12:0]      ofs;
    test_name = "bank_masks";
    install_page(tlb_key({31'h0200, 13'h0}, 1'b0), 1'b0, 1'b1);
    for (int i = 0; i < 24; i++) begin
      sz  = size_codes[next_rand() % 18];
      ofs = next_rand() % 8192;
      op  = make_op({31'h0200, ofs}, sz, next_rand() % 32, attr_of(1'b1, 1'b0));
      issue_op(op);
      check_value("mop_out.en", 1, mop_out.en);
      check_value("sz", sz, mop_out.sz);
      check_value("bank0", op.bank0, mop_out.bank0);
      check_value("addr_low", ofs[1:0], mop_out.addr_low);
      check_value("banks", expected_banks(sz, op.bank0, ofs[1:0]), mop_out.banks);
    end
  endtask

  task automatic page_cross_lines();
    mop_t                  op;
    logic [VADDR_W-1:0]    va;
    logic [WALK_VPN_W-1:0] key;
    logic [12:0]           offsets [3] = '{13'h1f80, 13'h02a4, 13'h0510};
    test_name = "line_addresses";
    key = tlb_key({31'h0300, 13'h0}, 1'b0);
    install_page(key, 1'b0, 1'b1);
    install_page(key + 1'b1, 1'b0, 1'b1);
    for (int i = 0; i < 3; i++) begin
      va = {31'h0300, offsets[i]};
      op = make_op(va, SZ_B8, 5'd0, attr_of(1'b1, 1'b0));
      issue_op(op);
      check_value("odd", va[7], mop_out.odd);
      check_value("addr_even", even_line(va, frame_of(key), frame_of(key + 1'b1)),
                  mop_out.addr_even);
      check_value("addr_odd", {frame_of(key), va[12:8]}, mop_out.addr_odd);
    end
  endtask

  task automatic fault_case(input logic [PFN_W-1:0] page, input logic sys, input logic na,
                            input logic km, input logic [1:0] code);
    mop_t op;
    op = make_op({page, 13'h0040}, SZ_B2, 5'd7, attr_of(km, 1'b0));
    install_page(tlb_key(op.vaddr, 1'b0), sys, na);
    @(negedge clk);
    issue_op(op);
    check_value("mop_out.en", 1, mop_out.en);
    check_value("early page_fault", 0, page_fault);
    @(negedge clk);
    check_value("page_fault", code != 2'b00, page_fault);
    check_value("fault_code", code, fault_code);
  endtask

  task automatic privilege_faults();
    test_name = "page_faults";
    fault_case(31'h0400, 1'b1, 1'b1, 1'b0, 2'b10);
    fault_case(31'h0401, 1'b0, 1'b0, 1'b1, 2'b01);
    fault_case(31'h0402, 1'b1, 1'b1, 1'b1, 2'b00);
  endtask

  task automatic miss_case(input logic [PFN_W-1:0] page, input logic vm);
    mop_t op;
    int   n0;
    n0 = walks.size();
    op = make_op({page, 13'h0140}, SZ_B8, 5'd4, attr_of(1'b1, vm));
    issue_op(op);
    check_value("mop_out.en on miss", 0, mop_out.en);
    check_value("stall on miss", 1, stall);
    wait_walks(n0 + 1, 20);
    check_value("walk src", WSRC_MISS, walks[n0].src);
    check_value("walk vpn", tlb_key(op.vaddr, vm), walks[n0].vpn);
    check_value("walk attr", attr_of(1'b1, vm), walks[n0].attr);
    wait_out_en(40);
    check_value("addr_odd", {frame_of(tlb_key(op.vaddr, vm)), op.vaddr[12:8]},
                mop_out.addr_odd);
    @(negedge clk);
  endtask

  task automatic miss_then_walk();
    test_name = "miss_walk";
    pbase = 21'h0a5a5;
    write_csr(CSR_PAGE, pbase);
    miss_case(31'h2000, 1'b0);
    vbase = 21'h13c3c;
    write_csr(CSR_VMPAGE, vbase);
    miss_case(31'h2001, 1'b1);
  endtask

  task automatic walk_source_order();
    mop_t                  op;
    int                    n0;
    int                    a0;
    logic [WALK_VPN_W-1:0] ext_key;
    logic [WALK_VPN_W-1:0] code_key;
    test_name = "walk_priority";
    n0       = walks.size();
    a0       = ack_count;
    ext_key  = {21'h00e1, 31'h5100};
    code_key = {21'h00c2, 31'h6200};
    op = make_op({31'h3000, 13'h0008}, SZ_B1, 5'd9, attr_of(1'b1, 1'b0));
    issue_op(op);
    wait_walks(n0 + 1, 20);
    // both arrive while the miss walk is still busy
    ext_req   = 1'b1;
    ext_vpn   = ext_key;
    ext_attr  = attr_of(1'b0, 1'b0);
    code_req  = 1'b1;
    code_vpn  = code_key;
    code_attr = attr_of(1'b1, 1'b0);
    @(negedge clk);
    ext_req  = 1'b0;
    code_req = 1'b0;
    wait_walks(n0 + 3, 60);
    wait_out_en(60);
    check_value("first src", WSRC_MISS, walks[n0].src);
    check_value("second src", WSRC_EXT, walks[n0 + 1].src);
    check_value("second vpn", ext_key, walks[n0 + 1].vpn);
    check_value("second attr", attr_of(1'b0, 1'b0), walks[n0 + 1].attr);
    check_value("third src", WSRC_CODE, walks[n0 + 2].src);
    check_value("third vpn", code_key, walks[n0 + 2].vpn);
    check_value("third attr", attr_of(1'b1, 1'b0), walks[n0 + 2].attr);
    check_value("ext_ack pulses", 1, ack_count - a0);
  endtask

  initial begin : watchdog
    repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
    $display("timeout: tests still running after %0d cycles", NUM_TESTS * CYCLES_PER_TEST);
    fail_run();
  end

  initial begin
    rst       = 1'b1;
    except    = 1'b0;
    rs_stall  = 1'b0;
    mop_in    = '0;
    ext_req   = 1'b0;
    ext_vpn   = '0;
    ext_attr  = '0;
    code_req  = 1'b0;
    code_vpn  = '0;
    code_attr = '0;
    csr_en    = 1'b0;
    csr_no    = '0;
    csr_data  = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    reset_then_hit();
    random_bank_masks();
    page_cross_lines();
    privilege_faults();
    miss_then_walk();
    walk_source_order();
    if (errors == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      fail_run();
    end
  end

endmodule

`default_nettype wire

//--- files.f
common/agu_pkg.sv
agu/mop_stage.sv
agu/bank_mask.sv
agu/line_addr.sv
agu/walk_arbiter.sv
rtl/page_csr.sv
rtl/agu_top.sv
bench/tb_agu.sv

//--- Bender.yml
package:
  name: agu

sources:
  - common/agu_pkg.sv
  - agu/mop_stage.sv
  - agu/bank_mask.sv
  - agu/line_addr.sv
  - agu/walk_arbiter.sv
  - rtl/page_csr.sv
  - rtl/agu_top.sv
  - target: simulation
    files:
      - bench/tb_agu.sv
